// ==== rtl/motion_cmd_pkg.sv ====
`default_nettype none

package motion_cmd_pkg;

  // Host word format, little endian 64-bit words
  localparam int WORD_W = 64;

  // Header byte sits in the top of every first word
  localparam int HDR_MSB = 63;
  localparam int HDR_LSB = 56;

  // Opcodes
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE     = 8'h0A;
  localparam logic [7:0] CMD_CLK_DIVISOR      = 8'h0B;
  localparam logic [7:0] CMD_MOTORCONFIG      = 8'h10;
  localparam logic [7:0] CMD_API_VERSION      = 8'hFE;

  // Current field of the motorconfig word starts here, microsteps at bit 0
  localparam int CURRENT_LSB = 8;

  // Reported in response bits 23:16, 15:8, 7:0
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd1;

endpackage

`default_nettype wire

// ==== rtl/motion_cfg_pkg.sv ====
`default_nettype none

package motion_cfg_pkg;

  // Queue depths
  localparam int CMD_DEPTH  = 2;
  localparam int MOVE_DEPTH = 4;

  // Move record: dir | duration | increment | increment-of-increment
  localparam int MOVE_W     = 193;
  localparam int DIR_BIT    = 192;
  localparam int DUR_MSB    = 191;
  localparam int DUR_LSB    = 128;
  localparam int INC_MSB    = 127;
  localparam int INC_LSB    = 64;
  localparam int INCINC_MSB = 63;
  localparam int INCINC_LSB = 0;

  // Settings register widths and reset values
  localparam int DIVISOR_W    = 8;
  localparam int MICROSTEPS_W = 3;
  localparam int CURRENT_W    = 8;
  localparam logic [DIVISOR_W-1:0]    DIVISOR_RST    = 8'd40;
  localparam logic [MICROSTEPS_W-1:0] MICROSTEPS_RST = 3'd2;
  localparam logic [CURRENT_W-1:0]    CURRENT_RST    = 8'd140;

  // Register selectors between decoder and register block
  localparam int REG_SEL_W = 2;
  localparam logic [REG_SEL_W-1:0] REG_ENABLE      = 2'd0;
  localparam logic [REG_SEL_W-1:0] REG_DIVISOR     = 2'd1;
  localparam logic [REG_SEL_W-1:0] REG_MOTORCONFIG = 2'd2;

endpackage

`default_nettype wire

// ==== rtl/payload_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_queue #(
  parameter type payload_t = logic [63:0],
  parameter int  DEPTH     = 2
) (
  input  wire           CLK,
  input  wire           resetn,
  input  wire           in_valid,
  output logic          in_ready,
  input  wire payload_t in_data,
  output logic          out_valid,
  input  wire           out_ready,
  output payload_t      out_data
);

  // Storage array
  payload_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic push;
  logic pop;

  // Full and empty straight from occupancy
  assign in_ready  = (count != $bits(count)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
  input  wire                                      CLK,
  input  wire                                      resetn,
  input  wire                                      word_valid,
  output logic                                     word_ready,
  input  wire [motion_cmd_pkg::WORD_W-1:0]         word_data,
  output logic                                     resp_valid,
  input  wire                                      resp_ready,
  output logic [motion_cmd_pkg::WORD_W-1:0]        resp_data,
  output logic                                     move_in_valid,
  input  wire                                      move_in_ready,
  output logic [motion_cfg_pkg::MOVE_W-1:0]        move_in_data,
  output logic                                     reg_we,
  output logic [motion_cfg_pkg::REG_SEL_W-1:0]     reg_sel,
  output logic [motion_cmd_pkg::WORD_W-1:0]        reg_wdata,
  input  wire signed [motion_cmd_pkg::WORD_W-1:0]  enc_count
);

  logic [motion_cmd_pkg::HDR_MSB-motion_cmd_pkg::HDR_LSB:0] opcode;
  logic [motion_cmd_pkg::HDR_MSB-motion_cmd_pkg::HDR_LSB:0] hdr;
  logic [1:0] word_idx;
  logic in_move;
  logic last_word;
  logic accept;
  logic mv_dir;
  logic [motion_cmd_pkg::WORD_W-1:0] mv_dur;
  logic [motion_cmd_pkg::WORD_W-1:0] mv_inc;
  logic signed [motion_cmd_pkg::WORD_W-1:0] enc_snap;
  logic [motion_cmd_pkg::WORD_W-1:0] resp_next;
  logic [motion_cfg_pkg::REG_SEL_W-1:0] sel_next;

  assign opcode = word_data[motion_cmd_pkg::HDR_MSB:motion_cmd_pkg::HDR_LSB];

  // Nonzero header only while a move is being gathered
  assign in_move   = (hdr == motion_cmd_pkg::CMD_COORDINATED_STEP);
  assign last_word = in_move && (word_idx == 2'd3);

  // One word at a time, never with a response outstanding
  // Final move word waits for room in the move queue
  assign word_ready = !resp_valid && (!last_word || move_in_ready);
  assign accept     = word_valid && word_ready;

  // Record goes out together with the last word, so it transfers on the same edge
  assign move_in_valid = word_valid && !resp_valid && last_word;

  always_comb begin
    move_in_data = '0;
    move_in_data[motion_cfg_pkg::DIR_BIT] = mv_dir;
    move_in_data[motion_cfg_pkg::DUR_MSB:motion_cfg_pkg::DUR_LSB] = mv_dur;
    move_in_data[motion_cfg_pkg::INC_MSB:motion_cfg_pkg::INC_LSB] = mv_inc;
    move_in_data[motion_cfg_pkg::INCINC_MSB:motion_cfg_pkg::INCINC_LSB] = word_data;
  end

  // Response payload for the word being accepted
  always_comb begin
    resp_next = '0;
    if (in_move) begin
      // Increment word reports the count latched at the header
      if (word_idx == 2'd2) begin
        resp_next = enc_snap;
      end
    end else if (opcode == motion_cmd_pkg::CMD_API_VERSION) begin
      resp_next[23:16] = motion_cmd_pkg::VERSION_MAJOR;
      resp_next[15:8]  = motion_cmd_pkg::VERSION_MINOR;
      resp_next[7:0]   = motion_cmd_pkg::VERSION_PATCH;
    end
  end

  // Selector for the single-word settings commands
  always_comb begin
    case (opcode)
      motion_cmd_pkg::CMD_MOTOR_ENABLE: sel_next = motion_cfg_pkg::REG_ENABLE;
      motion_cmd_pkg::CMD_CLK_DIVISOR:  sel_next = motion_cfg_pkg::REG_DIVISOR;
      default:                          sel_next = motion_cfg_pkg::REG_MOTORCONFIG;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      hdr        <= '0;
      word_idx   <= '0;
      resp_valid <= 1'b0;
      reg_we     <= 1'b0;
    end else begin
      reg_we <= 1'b0;
      if (resp_valid && resp_ready) begin
        resp_valid <= 1'b0;
      end
      if (accept) begin
        resp_valid <= 1'b1;
        if (in_move) begin
          if (last_word) begin
            hdr      <= '0;
            word_idx <= '0;
          end else begin
            word_idx <= word_idx + 2'd1;
          end
        end else begin
          case (opcode)
            motion_cmd_pkg::CMD_COORDINATED_STEP: begin
              hdr      <= opcode;
              word_idx <= 2'd1;
            end
            motion_cmd_pkg::CMD_MOTOR_ENABLE,
            motion_cmd_pkg::CMD_CLK_DIVISOR,
            motion_cmd_pkg::CMD_MOTORCONFIG: reg_we <= 1'b1;
            // Unknown opcodes only get their zero response
            default: ;
          endcase
        end
      end
    end
  end

  // Payload capture
  always_ff @(posedge CLK) begin
    if (accept) begin
      resp_data <= resp_next;
      reg_wdata <= word_data;
      reg_sel   <= sel_next;
      if (!in_move && opcode == motion_cmd_pkg::CMD_COORDINATED_STEP) begin
        mv_dir   <= word_data[0];
        enc_snap <= enc_count;
      end
      if (in_move && word_idx == 2'd1) begin
        mv_dur <= word_data;
      end
      if (in_move && word_idx == 2'd2) begin
        mv_inc <= word_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/motor_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_config_regs (
  input  wire                                      CLK,
  input  wire                                      resetn,
  input  wire                                      reg_we,
  input  wire [motion_cfg_pkg::REG_SEL_W-1:0]      reg_sel,
  input  wire [motion_cmd_pkg::WORD_W-1:0]         reg_wdata,
  output logic                                     enable,
  output logic [motion_cfg_pkg::DIVISOR_W-1:0]     divisor,
  output logic [motion_cfg_pkg::MICROSTEPS_W-1:0]  microsteps,
  output logic [motion_cfg_pkg::CURRENT_W-1:0]     current
);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      // Motor starts disabled
      enable     <= 1'b0;
      divisor    <= motion_cfg_pkg::DIVISOR_RST;
      microsteps <= motion_cfg_pkg::MICROSTEPS_RST;
      current    <= motion_cfg_pkg::CURRENT_RST;
    end else if (reg_we) begin
      case (reg_sel)
        motion_cfg_pkg::REG_ENABLE: enable <= reg_wdata[0];
        motion_cfg_pkg::REG_DIVISOR: divisor <= reg_wdata[motion_cfg_pkg::DIVISOR_W-1:0];
        motion_cfg_pkg::REG_MOTORCONFIG: begin
          // Microsteps and current written together
          microsteps <= reg_wdata[motion_cfg_pkg::MICROSTEPS_W-1:0];
          current    <= reg_wdata[motion_cmd_pkg::CURRENT_LSB +: motion_cfg_pkg::CURRENT_W];
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dda_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dda_timer (
  input  wire                                   CLK,
  input  wire                                   resetn,
  input  wire                                   move_valid,
  output logic                                  move_ready,
  input  wire [motion_cfg_pkg::MOVE_W-1:0]      move_data,
  input  wire [motion_cfg_pkg::DIVISOR_W-1:0]   divisor,
  input  wire                                   halt,
  output logic                                  step,
  output logic                                  dir,
  output logic                                  move_done
);

  logic active;
  logic start;
  logic tick;
  logic [motion_cfg_pkg::DIVISOR_W-1:0] div_cnt;
  logic [motion_cfg_pkg::DIVISOR_W-1:0] div_lim;
  logic [63:0] remaining;
  logic [63:0] acc;
  logic [63:0] inc;
  logic [63:0] incinc;
  logic [64:0] acc_sum;

  // Next move only once the current one is over
  assign move_ready = !active;
  assign start      = move_valid && move_ready;

  // Divisor of zero behaves as one
  assign div_lim = (divisor == '0) ? 1'b1 : divisor;
  // >= so a divisor shrinking mid-count still ticks promptly
  assign tick    = active && !halt && (div_cnt >= div_lim - 1'b1);
  // Carry out is the step
  assign acc_sum = {1'b0, acc} + {1'b0, inc};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      active    <= 1'b0;
      div_cnt   <= '0;
      remaining <= '0;
      step      <= 1'b0;
      dir       <= 1'b0;
      move_done <= 1'b0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (start) begin
        dir       <= move_data[motion_cfg_pkg::DIR_BIT];
        remaining <= move_data[motion_cfg_pkg::DUR_MSB:motion_cfg_pkg::DUR_LSB];
        div_cnt   <= '0;
        // Zero duration finishes right away
        if (move_data[motion_cfg_pkg::DUR_MSB:motion_cfg_pkg::DUR_LSB] == '0) begin
          move_done <= 1'b1;
        end else begin
          active <= 1'b1;
        end
      end else if (tick) begin
        div_cnt   <= '0;
        step      <= acc_sum[64];
        remaining <= remaining - 64'd1;
        if (remaining == 64'd1) begin
          active    <= 1'b0;
          move_done <= 1'b1;
        end
      end else if (active && !halt) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Accumulator and ramp, cleared or loaded at move start
  always_ff @(posedge CLK) begin
    if (start) begin
      acc    <= '0;
      inc    <= move_data[motion_cfg_pkg::INC_MSB:motion_cfg_pkg::INC_LSB];
      incinc <= move_data[motion_cfg_pkg::INCINC_MSB:motion_cfg_pkg::INCINC_LSB];
    end else if (tick) begin
      acc <= acc_sum[63:0];
      inc <= inc + incinc;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/quad_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_encoder (
  input  wire                                      CLK,
  input  wire                                      resetn,
  input  wire                                      enc_a,
  input  wire                                      enc_b,
  output logic signed [motion_cmd_pkg::WORD_W-1:0] enc_count
);

  logic a_meta;
  logic a_sync;
  logic a_prev;
  logic b_meta;
  logic b_sync;
  logic b_prev;
  logic count_en;
  logic count_up;

  // Exactly one of A and B changed, a double change is dropped
  assign count_en = a_sync ^ a_prev ^ b_sync ^ b_prev;
  // Forward order 00, 10, 11, 01 (A leads)
  assign count_up = a_sync ^ b_prev;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_meta    <= 1'b0;
      a_sync    <= 1'b0;
      a_prev    <= 1'b0;
      b_meta    <= 1'b0;
      b_sync    <= 1'b0;
      b_prev    <= 1'b0;
      enc_count <= '0;
    end else begin
      // Two-flop synchronizers
      a_meta <= enc_a;
      a_sync <= a_meta;
      b_meta <= enc_b;
      b_sync <= b_meta;
      // Previous state for transition detect
      a_prev <= a_sync;
      b_prev <= b_sync;
      if (count_en) begin
        enc_count <= count_up ? enc_count + 1'b1 : enc_count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/motion_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module motion_core (
  input  wire                                      CLK,
  input  wire                                      resetn,
  input  wire                                      cmd_valid,
  output logic                                     cmd_ready,
  input  wire [motion_cmd_pkg::WORD_W-1:0]         cmd_data,
  output logic                                     resp_valid,
  input  wire                                      resp_ready,
  output logic [motion_cmd_pkg::WORD_W-1:0]        resp_data,
  input  wire                                      halt,
  input  wire                                      enc_a,
  input  wire                                      enc_b,
  output logic                                     step,
  output logic                                     dir,
  output logic                                     move_done,
  output logic                                     buffer_ready,
  output logic                                     enable,
  output logic [motion_cfg_pkg::MICROSTEPS_W-1:0]  microsteps,
  output logic [motion_cfg_pkg::CURRENT_W-1:0]     current,
  output logic signed [motion_cmd_pkg::WORD_W-1:0] enc_count
);

  // Command queue to decoder
  logic word_valid;
  logic word_ready;
  logic [motion_cmd_pkg::WORD_W-1:0] word_data;
  // Decoder to move queue
  logic move_in_valid;
  logic move_in_ready;
  logic [motion_cfg_pkg::MOVE_W-1:0] move_in_data;
  // Move queue to DDA
  logic move_valid;
  logic move_ready;
  logic [motion_cfg_pkg::MOVE_W-1:0] move_data;
  // Settings write port
  logic reg_we;
  logic [motion_cfg_pkg::REG_SEL_W-1:0] reg_sel;
  logic [motion_cmd_pkg::WORD_W-1:0] reg_wdata;
  logic [motion_cfg_pkg::DIVISOR_W-1:0] divisor;

  // Host may send more moves while the queue has room
  assign buffer_ready = move_in_ready;

  payload_queue #(
    .payload_t (logic [motion_cmd_pkg::WORD_W-1:0]),
    .DEPTH     (motion_cfg_pkg::CMD_DEPTH)
  ) i_cmd_queue (
    .CLK       (CLK),
    .resetn    (resetn),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .in_data   (cmd_data),
    .out_valid (word_valid),
    .out_ready (word_ready),
    .out_data  (word_data)
  );

  command_decoder i_command_decoder (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_valid    (word_valid),
    .word_ready    (word_ready),
    .word_data     (word_data),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp_data     (resp_data),
    .move_in_valid (move_in_valid),
    .move_in_ready (move_in_ready),
    .move_in_data  (move_in_data),
    .reg_we        (reg_we),
    .reg_sel       (reg_sel),
    .reg_wdata     (reg_wdata),
    .enc_count     (enc_count)
  );

  payload_queue #(
    .payload_t (logic [motion_cfg_pkg::MOVE_W-1:0]),
    .DEPTH     (motion_cfg_pkg::MOVE_DEPTH)
  ) i_move_queue (
    .CLK       (CLK),
    .resetn    (resetn),
    .in_valid  (move_in_valid),
    .in_ready  (move_in_ready),
    .in_data   (move_in_data),
    .out_valid (move_valid),
    .out_ready (move_ready),
    .out_data  (move_data)
  );

  motor_config_regs i_motor_config_regs (
    .CLK        (CLK),
    .resetn     (resetn),
    .reg_we     (reg_we),
    .reg_sel    (reg_sel),
    .reg_wdata  (reg_wdata),
    .enable     (enable),
    .divisor    (divisor),
    .microsteps (microsteps),
    .current    (current)
  );

  dda_timer i_dda_timer (
    .CLK        (CLK),
    .resetn     (resetn),
    .move_valid (move_valid),
    .move_ready (move_ready),
    .move_data  (move_data),
    .divisor    (divisor),
    .halt       (halt),
    .step       (step),
    .dir        (dir),
    .move_done  (move_done)
  );

  quad_encoder i_quad_encoder (
    .CLK       (CLK),
    .resetn    (resetn),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .enc_count (enc_count)
  );

endmodule

`default_nettype wire

// ==== verification/motion_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module motion_core_props (
  input wire        CLK,
  input wire        resetn,
  input wire        step,
  input wire        move_done,
  input wire        move_valid,
  input wire        move_ready,
  input wire        resp_valid,
  input wire        resp_ready,
  input wire [63:0] resp_data
);

  // Moves taken by the DDA and not yet finished
  logic [7:0] moves_open;

  always @(posedge CLK) begin
    if (!resetn) begin
      moves_open <= 8'd0;
    end else begin
      moves_open <= moves_open + {7'd0, move_valid && move_ready} - {7'd0, move_done};
    end
  end

  // Single-cycle step pulse
  step_one_cycle: assert property (@(posedge CLK) disable iff (!resetn) step |=> !step)
    else $error("step high for more than one cycle");

  // Response held until taken
  resp_held: assert property (@(posedge CLK) disable iff (!resetn)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
    else $error("response changed before resp_ready");

  done_after_move: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |-> moves_open != 8'd0)
    else $error("move_done without an accepted move");

endmodule

bind motion_core motion_core_props i_motion_core_props (
  .CLK        (CLK),
  .resetn     (resetn),
  .step       (step),
  .move_done  (move_done),
  .move_valid (move_valid),
  .move_ready (move_ready),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .resp_data  (resp_data)
);

`default_nettype wire

// ==== verification/motion_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module motion_core_tb;

  localparam int TB_DIV  = 2;
  localparam int MAX_ENT = 24;
  localparam logic [63:0] VERSION_RESP = {40'd0, motion_cmd_pkg::VERSION_MAJOR,
                                          motion_cmd_pkg::VERSION_MINOR,
                                          motion_cmd_pkg::VERSION_PATCH};

  // DUT inputs
  logic        CLK        = 1'b0;
  logic        resetn     = 1'b0;
  logic        cmd_valid  = 1'b0;
  logic [63:0] cmd_data   = '0;
  logic        resp_ready = 1'b0;
  logic        halt       = 1'b0;
  logic        enc_a      = 1'b0;
  logic        enc_b      = 1'b0;
  // DUT outputs
  logic        cmd_ready;
  logic        resp_valid;
  logic [63:0] resp_data;
  logic        step;
  logic        dir;
  logic        move_done;
  logic        buffer_ready;
  logic        enable;
  logic [2:0]  microsteps;
  logic [7:0]  current;
  logic signed [63:0] enc_count;

  // Stimulus table with one command or one move per entry
  int          n_ent;
  int          ent_grp    [MAX_ENT];
  bit          ent_move   [MAX_ENT];
  logic [63:0] ent_word   [MAX_ENT];
  logic [63:0] ent_resp   [MAX_ENT];
  logic [63:0] ent_dur    [MAX_ENT];
  logic [63:0] ent_inc    [MAX_ENT];
  logic [63:0] ent_incinc [MAX_ENT];

  // Words still to send plus responses and moves still expected
  logic [63:0] send_q    [$];
  logic [63:0] exp_resp  [$];
  int          exp_steps [$];
  logic        exp_dir   [$];

  // Register and encoder model
  logic        m_enable;
  logic [7:0]  m_div;
  logic [2:0]  m_micro;
  logic [7:0]  m_cur;
  logic signed [63:0] enc_tally;
  int          enc_phase;

  int errors   = 0;
  int step_cnt = 0;
  int snap;
  bit resp_hold    = 1'b0;
  bit buf_low_seen = 1'b0;

  always #10 CLK = ~CLK;

  motion_core i_motion_core (
    .CLK          (CLK),
    .resetn       (resetn),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_data     (cmd_data),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp_data    (resp_data),
    .halt         (halt),
    .enc_a        (enc_a),
    .enc_b        (enc_b),
    .step         (step),
    .dir          (dir),
    .move_done    (move_done),
    .buffer_ready (buffer_ready),
    .enable       (enable),
    .microsteps   (microsteps),
    .current      (current),
    .enc_count    (enc_count)
  );

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    errors++;
    $display("ERR %s got %h expected %h", name, got, exp);
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  task automatic add_single(input int grp, input logic [63:0] word, input logic [63:0] resp);
    ent_grp[n_ent]  = grp;
    ent_move[n_ent] = 1'b0;
    ent_word[n_ent] = word;
    ent_resp[n_ent] = resp;
    ent_dur[n_ent]  = '0;
    n_ent++;
  endtask

  task automatic add_move(input int grp, input bit mdir, input logic [63:0] dur,
                          input logic [63:0] inc, input logic [63:0] incinc);
    ent_grp[n_ent]    = grp;
    ent_move[n_ent]   = 1'b1;
    ent_word[n_ent]   = {motion_cmd_pkg::CMD_COORDINATED_STEP, 55'd0, mdir};
    ent_dur[n_ent]    = dur;
    ent_inc[n_ent]    = inc;
    ent_incinc[n_ent] = incinc;
    n_ent++;
  endtask

  task automatic build_table();
    n_ent = 0;
    // Settings, then an unknown opcode, then plain, ramping and empty moves
    add_single(0, 64'hFE00_0000_0000_0000, VERSION_RESP);
    add_single(0, 64'h0A00_0000_0000_0001, '0);
    add_single(0, 64'h0B00_0000_0000_0000 | 64'(TB_DIV), '0);
    add_single(0, 64'h1000_0000_0000_C805, '0);
    add_single(0, 64'h3300_0000_0000_FFFF, '0);
    add_move(0, 1'b1, 10, 64'h4000_0000_0000_0000, '0);
    add_move(0, 1'b0, 16, 64'h1000_0000_0000_0000, 64'h0800_0000_0000_0000);
    add_move(0, 1'b1, 0, 64'hFFFF_FFFF_FFFF_FFFF, '0);
    // Encoder snapshot move
    add_move(1, 1'b0, 8, 64'h6000_0000_0000_0000, '0);
    // Long move with five more piling up behind it
    add_move(2, 1'b1, 300, 64'h0400_0000_0000_0000, '0);
    add_move(2, 1'b0, 6, 64'h8000_0000_0000_0000, '0);
    add_move(2, 1'b1, 9, 64'h5555_5555_5555_5556, '0);
    add_move(2, 1'b0, 12, 64'h0800_0000_0000_0000, 64'h1000_0000_0000_0000);
    add_move(2, 1'b1, 0, '0, '0);
    add_move(2, 1'b0, 5, 64'hFFFF_FFFF_FFFF_FFFF, '0);
    // Halted mid-move
    add_move(3, 1'b1, 40, 64'h8000_0000_0000_0000, '0);
    // Sent with resp_ready held low
    add_single(4, 64'hFE00_0000_0000_0000, VERSION_RESP);
    add_single(4, 64'h5500_0000_0000_1234, '0);
    add_single(4, 64'hFE00_0000_0000_0000, VERSION_RESP);
    add_single(4, 64'h1000_0000_0000_4003, '0);
  endtask

  // Carries out of the 64-bit accumulator over the move's ticks
  function automatic int model_steps(input logic [63:0] dur, input logic [63:0] inc,
                                     input logic [63:0] incinc);
    logic [63:0] acc;
    logic [63:0] acc_next;
    logic [63:0] cur;
    logic [63:0] t;
    int steps;
    acc   = '0;
    cur   = inc;
    steps = 0;
    for (t = 0; t < dur; t++) begin
      acc_next = acc + cur;
      // Wrapped below the old value means a carry
      if (acc_next < acc) begin
        steps++;
      end
      acc = acc_next;
      cur = cur + incinc;
    end
    return steps;
  endfunction

  task automatic push_word(input logic [63:0] word, input logic [63:0] resp);
    send_q.push_back(word);
    exp_resp.push_back(resp);
  endtask

  task automatic apply_entry(input int i);
    if (ent_move[i]) begin
      exp_steps.push_back(model_steps(ent_dur[i], ent_inc[i], ent_incinc[i]));
      exp_dir.push_back(ent_word[i][0]);
      push_word(ent_word[i], '0);
      push_word(ent_dur[i], '0);
      // Encoder is quiet while moves are sent
      push_word(ent_inc[i], enc_tally);
      push_word(ent_incinc[i], '0);
    end else begin
      push_word(ent_word[i], ent_resp[i]);
      case (ent_word[i][63:56])
        8'h0A: m_enable = ent_word[i][0];
        8'h0B: m_div = ent_word[i][7:0];
        8'h10: begin
          m_micro = ent_word[i][2:0];
          m_cur   = ent_word[i][15:8];
        end
        default: ;
      endcase
    end
  endtask

  task automatic wait_idle();
    @(negedge CLK);
    while (send_q.size() != 0 || cmd_valid || exp_resp.size() != 0 ||
           exp_steps.size() != 0) begin
      @(negedge CLK);
    end
    // Register outputs trail the response
    repeat (3) @(negedge CLK);
  endtask

  task automatic check_regs();
    if (enable !== m_enable) report_value("enable", 64'(enable), 64'(m_enable));
    if (i_motion_core.divisor !== m_div) begin
      report_value("divisor", 64'(i_motion_core.divisor), 64'(m_div));
    end
    if (microsteps !== m_micro) report_value("microsteps", 64'(microsteps), 64'(m_micro));
    if (current !== m_cur) report_value("current", 64'(current), 64'(m_cur));
  endtask

  task automatic run_group(input int g, input bit each);
    for (int i = 0; i < n_ent; i++) begin
      if (ent_grp[i] == g) begin
        @(negedge CLK);
        apply_entry(i);
        if (each) begin
          wait_idle();
          check_regs();
        end
      end
    end
  endtask

  // Gray order 00, 10, 11, 01 with A leading
  task automatic drive_phase();
    @(posedge CLK);
    enc_a <= (enc_phase == 1) || (enc_phase == 2);
    enc_b <= (enc_phase == 2) || (enc_phase == 3);
    repeat (4) @(posedge CLK);
  endtask

  task automatic enc_move(input bit fwd);
    enc_phase = fwd ? (enc_phase + 1) % 4 : (enc_phase + 3) % 4;
    enc_tally = fwd ? enc_tally + 1 : enc_tally - 1;
    drive_phase();
  endtask

  // Both lines flip at once and nothing is counted
  task automatic enc_double();
    enc_phase = (enc_phase + 2) % 4;
    drive_phase();
  endtask

  // Word sender runs back to back when the queue allows
  always @(posedge CLK) begin
    if (!cmd_valid || cmd_ready) begin
      if (send_q.size() != 0) begin
        cmd_data  <= send_q.pop_front();
        cmd_valid <= 1'b1;
      end else begin
        cmd_valid <= 1'b0;
      end
    end
  end

  // Response checker and random resp_ready
  initial begin
    void'($urandom(61519));
    forever begin
      @(posedge CLK);
      if (resp_valid && resp_ready) begin
        if (exp_resp.size() == 0) begin
          report_fault("response arrived with none outstanding");
        end else begin
          if (resp_data !== exp_resp[0]) report_value("resp_data", resp_data, exp_resp[0]);
          void'(exp_resp.pop_front());
        end
      end
      resp_ready <= resp_hold ? 1'b0 : (($urandom % 4) != 0);
    end
  end

  // Step, dir and move_done monitor
  always @(posedge CLK) begin
    if (resetn) begin
      if (!buffer_ready) buf_low_seen = 1'b1;
      if (step) begin
        step_cnt++;
        if (exp_dir.size() != 0 && dir !== exp_dir[0]) begin
          report_value("dir", 64'(dir), 64'(exp_dir[0]));
        end
      end
      if (move_done) begin
        if (exp_steps.size() == 0) begin
          report_fault("move_done pulsed with no move outstanding");
        end else begin
          if (step_cnt != exp_steps[0]) begin
            report_value("step count", 64'(step_cnt), 64'(exp_steps[0]));
          end
          if (dir !== exp_dir[0]) report_value("dir", 64'(dir), 64'(exp_dir[0]));
          void'(exp_steps.pop_front());
          void'(exp_dir.pop_front());
        end
        step_cnt = 0;
      end
    end
  end

  // Watchdog sized from the table's move durations
  initial begin
    int limit;
    @(posedge resetn);
    limit = 3000;
    for (int i = 0; i < n_ent; i++) begin
      limit = limit + int'(ent_dur[i]) * TB_DIV + 100;
    end
    repeat (limit) @(posedge CLK);
    $display("Timeout: run did not finish within %0d cycles", limit);
    $display("tests failed");
    $finish;
  end

  initial begin
    build_table();
    m_enable  = 1'b0;
    m_div     = 8'd40;
    m_micro   = 3'd2;
    m_cur     = 8'd140;
    enc_tally = '0;
    enc_phase = 0;
    repeat (10) @(posedge CLK);
    resetn <= 1'b1;
    @(negedge CLK);

    // Reset values
    if (step !== 1'b0) report_value("step", 64'(step), 64'd0);
    if (move_done !== 1'b0) report_value("move_done", 64'(move_done), 64'd0);
    if (resp_valid !== 1'b0) report_value("resp_valid", 64'(resp_valid), 64'd0);
    if (buffer_ready !== 1'b1) report_value("buffer_ready", 64'(buffer_ready), 64'd1);
    if (enc_count !== '0) report_value("enc_count", enc_count, 64'd0);
    check_regs();

    // Version, settings, unknown opcode, basic moves
    run_group(0, 1'b1);

    // Quadrature forward, back, and an ignored double edge
    for (int i = 0; i < 7; i++) enc_move(1'b1);
    enc_move(1'b0);
    enc_move(1'b0);
    enc_double();
    @(negedge CLK);
    if (enc_count !== enc_tally) report_value("enc_count", enc_count, enc_tally);
    run_group(1, 1'b1);
    // Reverse past zero
    for (int i = 0; i < 9; i++) enc_move(1'b0);
    @(negedge CLK);
    if (enc_count !== enc_tally) report_value("enc_count", enc_count, enc_tally);

    // Stalled responses back up the command stream
    resp_hold = 1'b1;
    repeat (3) @(negedge CLK);
    run_group(4, 1'b0);
    repeat (20) @(negedge CLK);
    if (cmd_ready !== 1'b0) report_value("cmd_ready", 64'(cmd_ready), 64'd0);
    if (resp_valid !== 1'b1) report_value("resp_valid", 64'(resp_valid), 64'd1);
    resp_hold = 1'b0;
    wait_idle();
    check_regs();

    // Move queue fills behind the long move
    buf_low_seen = 1'b0;
    run_group(2, 1'b0);
    wait_idle();
    if (!buf_low_seen) report_fault("buffer_ready never dropped with the move queue full");

    // Halt in the middle of a move
    run_group(3, 1'b0);
    while (step_cnt < 3) @(negedge CLK);
    @(posedge CLK);
    halt <= 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    snap = step_cnt;
    repeat (100) @(negedge CLK);
    if (step_cnt != snap) report_fault("step pulses continued while halt was high");
    if (exp_steps.size() != 1) report_fault("halted move ended while halted");
    @(posedge CLK);
    halt <= 1'b0;
    wait_idle();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/motion_cmd_pkg.sv
rtl/motion_cfg_pkg.sv
rtl/payload_queue.sv
rtl/command_decoder.sv
rtl/motor_config_regs.sv
rtl/dda_timer.sv
rtl/quad_encoder.sv
rtl/motion_core.sv
verification/motion_core_props.sv
verification/motion_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the motion core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module motion_core_tb -o sim_motion_core > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
# A simulator that stops on its own counts as a failed run
./obj_dir/sim_motion_core > sim.log 2>&1 || echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
